// ==== fibCore.f ====
hw/isaPkg.sv
hw/seqPkg.sv
hw/ctrlIf.sv
hw/dataIf.sv
hw/fibSequencer.sv
hw/regFile.sv
hw/alu.sv
hw/fibCore.sv
sim/fibCore_assertions.sv
sim/fibCoreTb.sv

// ==== hw/alu.sv ====
module alu
	import isaPkg::*;
(
	ctrlIf.dp  ctrl,
	dataIf.alu data
);

	// Second operand after the immediate mux
	dataT operandB;

	// Zero-extended immediate
	dataT immExt;

	assign immExt = dataT'(ctrl.imm);

	assign operandB = ctrl.selectImm ? immExt : data.opB;

	////////////////////////////////////////////////////////////////////////////
	// Operation select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (ctrl.op)
			// Register and immediate adds differ only in operandB
			opAdd, opAddi: begin
				data.result = data.opA + operandB;
			end
			// opOr and anything unknown
			default: begin
				data.result = data.opA | operandB;
			end
		endcase
	end

endmodule

// ==== hw/ctrlIf.sv ====
interface ctrlIf
	import isaPkg::*;
();

	// Operand B comes from the immediate instead of read port B
	logic    selectImm;

	// Write strobe and target for the register file
	logic    writeEn;
	regAddrT writeAddr;

	// Read port selects
	regAddrT readAddrA;
	regAddrT readAddrB;

	immT     imm;
	aluOpT   op;

	// Sequencer side
	modport seq (
		output selectImm, writeEn, writeAddr, readAddrA, readAddrB, imm, op
	);

	// Register file and ALU side
	modport dp (
		input selectImm, writeEn, writeAddr, readAddrA, readAddrB, imm, op
	);

endinterface

// ==== hw/dataIf.sv ====
interface dataIf
	import isaPkg::*;
();

	// Read port values from the register file
	dataT opA;
	dataT opB;

	// ALU output, also the register write data
	dataT result;

	modport rf (
		output opA, opB,
		input  result
	);

	modport alu (
		input  opA, opB,
		output result
	);

endinterface

// ==== hw/fibCore.sv ====
module fibCore
	import isaPkg::*;
(
	input  logic    clk,
	input  logic    arstN,
	input  regAddrT sel,
	output dataT    result,
	output logic    done
);

	////////////////////////////////////////////////////////////////////////////
	// Internal buses
	////////////////////////////////////////////////////////////////////////////

	// Control word, sequencer to datapath
	ctrlIf ctrl ();

	// Operands and result between register file and ALU
	dataIf data ();

	////////////////////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////////////////////

	fibSequencer seqInst (
		.clk   (clk),
		.arstN (arstN),
		.sel   (sel),
		.done  (done),
		.ctrl  (ctrl.seq)
	);

	regFile rfInst (
		.clk   (clk),
		.arstN (arstN),
		.ctrl  (ctrl.dp),
		.data  (data.rf)
	);

	alu aluInst (
		.ctrl (ctrl.dp),
		.data (data.alu)
	);

	// Same value that is written back during the program
	assign result = data.result;

endmodule

// ==== hw/fibSequencer.sv ====
module fibSequencer
	import isaPkg::*;
	import seqPkg::*;
(
	input  logic    clk,
	input  logic    arstN,
	input  regAddrT sel,
	output logic    done,
	ctrlIf.seq      ctrl
);

	seqStateT state;
	seqStateT stateNext;

	// Also the register written in the current step
	regAddrT  stepIdx;

	// Register shown once the program has finished
	regAddrT  doneAddr;

	////////////////////////////////////////////////////////////////////////////
	// State and step counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state   <= stepInit;
			stepIdx <= '0;
		end else begin
			state <= stateNext;
			// Counter freezes once done
			if (state != stepDone) begin
				stepIdx <= stepIdx + regAddrT'(1);
			end
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			stepInit: begin
				if (stepIdx == regAddrT'(initSteps - 1)) begin
					stateNext = stepAdd;
				end
			end
			stepAdd: begin
				// Last write goes to r15
				if (stepIdx == regAddrT'(progSteps - 1)) begin
					stateNext = stepDone;
				end
			end
			stepDone: begin
				stateNext = stepDone;
			end
			default: begin
				stateNext = stepInit;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Control word decode
	////////////////////////////////////////////////////////////////////////////

	// A select of zero maps to the last register
	assign doneAddr = (sel == '0) ? regAddrT'(numRegs - 1) : sel;

	always_comb begin
		// Done state word, read only
		ctrl.selectImm = 1'b0;
		ctrl.writeEn   = 1'b0;
		ctrl.writeAddr = stepIdx;
		ctrl.readAddrA = doneAddr;
		ctrl.readAddrB = doneAddr;
		ctrl.imm       = '0;
		ctrl.op        = opOr;

		if (state == stepInit) begin
			// rN = r2 + 1 with r2 still cleared
			ctrl.selectImm = 1'b1;
			ctrl.writeEn   = 1'b1;
			ctrl.readAddrA = regAddrT'(initBaseReg);
			ctrl.readAddrB = regAddrT'(initBaseReg);
			ctrl.imm       = immT'(initValue);
			ctrl.op        = opAddi;
		end else if (state == stepAdd) begin
			// rN = rN-1 + rN-2
			ctrl.writeEn   = 1'b1;
			ctrl.readAddrA = stepIdx - regAddrT'(1);
			ctrl.readAddrB = stepIdx - regAddrT'(2);
			ctrl.op        = opAdd;
		end
	end

	assign done = (state == stepDone);

endmodule

// ==== hw/isaPkg.sv ====
package isaPkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////////////////////

	// Width of every register and of the ALU result
	localparam int dataW = 16;

	// Register index width, fixes the register count
	localparam int regAddrW = 4;

	// Immediate field as carried in the control word
	localparam int immW = 8;

	// Opcode field width
	localparam int opW = 8;

	// Register file depth
	localparam int numRegs = 2 ** regAddrW;

	////////////////////////////////////////////////////////////////////////////
	// Value types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [dataW-1:0] dataT;

	typedef logic [regAddrW-1:0] regAddrT;

	// Zero-extended to dataT before use in the ALU
	typedef logic [immW-1:0] immT;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////////////////////

	// Encodings kept from the original hard-wired controller
	typedef enum logic [opW-1:0] {
		opAdd  = 8'h05,
		opAddi = 8'h50,
		opOr   = 8'h02
	} aluOpT;

endpackage

// ==== hw/regFile.sv ====
module regFile
	import isaPkg::*;
(
	input logic clk,
	input logic arstN,
	ctrlIf.dp   ctrl,
	dataIf.rf   data
);

	// Register storage
	dataT regs [numRegs];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	// All registers start from zero, the seed steps depend on r2 being clear
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.writeEn) begin
			regs[ctrl.writeAddr] <= data.result;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////////////////////

	// Combinational, a write shows up the cycle after its edge
	assign data.opA = regs[ctrl.readAddrA];
	assign data.opB = regs[ctrl.readAddrB];

endmodule

// ==== hw/seqPkg.sv ====
package seqPkg;

	////////////////////////////////////////////////////////////////////////////
	// Sequencer states
	////////////////////////////////////////////////////////////////////////////

	// Load seeds, run the additions, then hold
	typedef enum logic [1:0] {
		stepInit = 2'd0,
		stepAdd  = 2'd1,
		stepDone = 2'd2
	} seqStateT;

	////////////////////////////////////////////////////////////////////////////
	// Program shape
	////////////////////////////////////////////////////////////////////////////

	// Writing steps, one per register
	localparam int progSteps = 16;

	// ADDI steps that seed r0 and r1
	localparam int initSteps = 2;

	// Seed value for the first two registers
	localparam int initValue = 1;

	// Still zero during the seed steps, so it serves as the ADDI base
	localparam int initBaseReg = 2;

endpackage

// ==== runSim.sh ====
#!/bin/sh
# Builds the fibCore testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
	--top-module fibCoreTb \
	-f fibCore.f \
	-o fibCoreSim

# A failing run ends in $fatal, so the exit status carries the result
./obj_dir/fibCoreSim

// ==== sim/fibCoreTb.sv ====
module fibCoreTb
	import isaPkg::*;
	import seqPkg::*;
();

	localparam int clkHalf = 4;
	localparam int resetCycles = 10;
	localparam int randomSels = 200;
	localparam logic [31:0] lfsrSeed = 32'hf3b2_b182;

	// Taps of x^32 + x^31 + x^29 + x + 1, shifting right
	localparam logic [31:0] lfsrTaps = 32'hd000_0001;

	logic    clk = 1'b0;
	logic    arstN;
	regAddrT sel;
	dataT    result;
	logic    done;

	logic [31:0] lfsrState;

	// Expected values, set by the stimulus and read by the compare process
	dataT expResult;
	bit   expDone;
	bit   checkResult;
	bit   checkEnable;

	always #clkHalf clk = ~clk;

	fibCore fibCore_inst (
		.clk    (clk),
		.arstN  (arstN),
		.sel    (sel),
		.result (result),
		.done   (done)
	);

	bind fibSequencer fibCoreAssertions asrtInst (
		.clk       (clk),
		.arstN     (arstN),
		.done      (done),
		.writeEn   (ctrl.writeEn),
		.writeAddr (ctrl.writeAddr)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// n-th Fibonacci number, counted from fib(1) = fib(2) = 1
	function automatic dataT fibRef(input int n);
		dataT prev;
		dataT cur;
		dataT nxt;
		prev = dataT'(1);
		cur = dataT'(1);
		for (int i = 3; i <= n; i++) begin
			nxt = prev + cur;
			prev = cur;
			cur = nxt;
		end
		return cur;
	endfunction

	// Value on result in the done state, r15 for a zero select
	function automatic dataT shownRef(input regAddrT s);
		if (s == '0) begin
			return fibRef(progSteps);
		end
		return fibRef(int'(s) + 1);
	endfunction

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ lfsrTaps;
		end
		return s >> 1;
	endfunction

	// One LFSR step per select bit
	task automatic drawSel(output regAddrT value);
		value = '0;
		for (int i = 0; i < 4; i++) begin
			value = {value[2:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "fibCoreTb stopped at the first failure");
	endtask

	task automatic checkData(input string name, input dataT actual, input dataT expected);
		if (actual !== expected) begin
			failRun($sformatf("ERR time=%0t %s actual=%0d expected=%0d",
				$time, name, actual, expected));
		end
	endtask

	task automatic checkDone(input string name, input bit actual, input bit expected);
		if (actual !== expected) begin
			failRun($sformatf("ERR time=%0t %s actual=%0b expected=%0b",
				$time, name, actual, expected));
		end
	endtask

	// Mid-cycle sampling, inputs move just after the rising edge
	always @(negedge clk) begin
		if (checkEnable) begin
			checkDone("done", done, expDone);
			if (checkResult) begin
				checkData("result", result, expResult);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	// Released one time unit after the last reset edge, step 0 follows
	task automatic applyReset();
		checkResult = 1'b0;
		expDone = 1'b0;
		sel = '0;
		arstN = 1'b0;
		for (int i = 0; i < resetCycles; i++) begin
			nextCycle();
		end
		arstN = 1'b1;
	endtask

	// Step k shows fib(k+1) before it is written into register k
	task automatic runProgram(input int steps);
		for (int k = 0; k < steps; k++) begin
			expDone = 1'b0;
			expResult = fibRef(k + 1);
			checkResult = 1'b1;
			nextCycle();
		end
	endtask

	task automatic waitForDone(input int cyclesSoFar);
		int cycles;
		cycles = cyclesSoFar;
		checkEnable = 1'b0;
		while (done !== 1'b1) begin
			if (cycles >= progSteps + 20) begin
				failRun("Timeout: done never went high after reset release");
			end
			nextCycle();
			cycles++;
		end
		if (cycles != progSteps) begin
			failRun($sformatf("done went high %0d cycles after reset release, not %0d",
				cycles, progSteps));
		end
		expDone = 1'b1;
		checkEnable = 1'b1;
	endtask

	// Zero select first, then random registers
	task automatic checkSelects(input int count);
		regAddrT s;
		expDone = 1'b1;
		sel = '0;
		expResult = shownRef('0);
		checkResult = 1'b1;
		nextCycle();
		for (int i = 0; i < count; i++) begin
			drawSel(s);
			sel = s;
			expResult = shownRef(s);
			nextCycle();
		end
	endtask

	initial begin
		arstN = 1'b0;
		sel = '0;
		lfsrState = lfsrSeed;
		expResult = '0;
		expDone = 1'b0;
		checkResult = 1'b0;
		checkEnable = 1'b1;

		// Full program, then the read-back phase
		applyReset();
		runProgram(progSteps);
		waitForDone(progSteps);
		checkSelects(randomSels);

		// Reset out of the done state
		applyReset();
		runProgram(progSteps);
		waitForDone(progSteps);
		checkSelects(20);

		// Reset in the middle of the program
		applyReset();
		runProgram(7);
		applyReset();
		runProgram(progSteps);
		waitForDone(progSteps);
		checkSelects(20);

		checkEnable = 1'b0;
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== sim/fibCore_assertions.sv ====
module fibCoreAssertions
	import isaPkg::*;
(
	input logic    clk,
	input logic    arstN,
	input logic    done,
	input logic    writeEn,
	input regAddrT writeAddr
);

	// Registers written since the last reset
	logic [numRegs-1:0] writtenMask;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			writtenMask <= '0;
		end else if (writeEn) begin
			writtenMask[writeAddr] <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Control word properties
	////////////////////////////////////////////////////////////////////////////

	// No write strobe once the program has finished
	noWriteWhenDone: assert property (
		@(posedge clk) disable iff (!arstN)
		done |-> !writeEn
	) else $error("writeEn is high while done is high");

	// Each register written once per run
	uniqueWriteAddr: assert property (
		@(posedge clk) disable iff (!arstN)
		writeEn |-> !writtenMask[writeAddr]
	) else $error("writeAddr %0d written a second time", writeAddr);

endmodule
